//--- design/cart_config.svh
`ifndef CART_CONFIG_SVH
`define CART_CONFIG_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// Byte address seen by console and MCU
`define CART_ADDR_W 24

// One byte lane
`define CART_DATA_W 8

//////////////////////////////////////////////////
// Memory timing
//////////////////////////////////////////////////

// Wait cycles of every external memory access
`define CART_MEM_WAIT 3

`endif

//--- design/cart_bus_pkg.sv
`default_nettype none

`include "cart_config.svh"

package cart_bus_pkg;

  // Console side, read and write are levels
  typedef struct packed {
    logic [`CART_ADDR_W-1:0] addr;
    logic                    read;
    logic                    write;
    logic [`CART_DATA_W-1:0] wdata;
  } console_req_t;

  // MCU side, req is a one cycle pulse
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [`CART_ADDR_W-1:0] addr;
    logic [`CART_DATA_W-1:0] wdata;
  } mcu_req_t;

  // Done pulse ends every MCU access
  typedef struct packed {
    logic                    done;
    logic [`CART_DATA_W-1:0] rdata;
  } mcu_rsp_t;

endpackage

`default_nettype wire

//--- design/cart_mem_pkg.sv
`default_nettype none

`include "cart_config.svh"

package cart_mem_pkg;

  // External 16-bit memory, word addressed
  typedef struct packed {
    logic [`CART_ADDR_W-2:0]   addr;
    logic                      we;
    logic                      oe;
    logic [2*`CART_DATA_W-1:0] wdata;
  } mem_port_t;

  // Latch load strobes plus the selected byte lane
  typedef struct packed {
    logic console_in;
    logic mcu_in;
    logic mem_to_console;
    logic mem_to_mcu;
    logic lane;
  } latch_strobe_t;

  typedef enum logic [1:0] {
    OWNER_IDLE,
    OWNER_CONSOLE,
    OWNER_MCU
  } owner_e;

endpackage

`default_nettype wire

//--- design/cart_data_path.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module cart_data_path (
  input  wire                              CLK,
  input  wire                              reset,
  input  wire cart_mem_pkg::latch_strobe_t strobe,
  input  wire                              mode,
  input  wire                              mcu_ovr,
  input  wire [`CART_DATA_W-1:0]           console_wdata,
  input  wire [`CART_DATA_W-1:0]           mcu_wdata,
  input  wire                              console_read,
  input  wire [2*`CART_DATA_W-1:0]         mem_rdata,
  output logic [2*`CART_DATA_W-1:0]        mem_wdata,
  output logic                             mem_oe,
  output logic [`CART_DATA_W-1:0]          console_rdata,
  output logic [`CART_DATA_W-1:0]          mcu_rdata
);

  logic [`CART_DATA_W-1:0] console_in_q;
  logic [`CART_DATA_W-1:0] console_out_q;
  logic [`CART_DATA_W-1:0] mcu_in_q;
  logic [`CART_DATA_W-1:0] mcu_out_q;
  logic [`CART_DATA_W-1:0] mem_byte;
  logic [`CART_DATA_W-1:0] src_byte;
  logic [`CART_DATA_W-1:0] wr_byte;
  logic                    console_wr_act;
  logic                    mcu_wr_act;
  logic                    src_act;

  // Bit 0 high picks the low lane
  assign mem_byte = strobe.lane ? mem_rdata[7:0] : mem_rdata[15:8];

  //////////////////////////////////////////////////
  // Byte latches
  //////////////////////////////////////////////////

  always_ff @(posedge CLK) begin
    if (strobe.console_in)
      console_in_q <= console_wdata;
    if (strobe.mcu_in)
      mcu_in_q <= mcu_wdata;
    if (strobe.mem_to_console)
      console_out_q <= mem_byte;
    if (strobe.mem_to_mcu)
      mcu_out_q <= mem_byte;
  end

  // A write source stays active from its load until its access ends
  always_ff @(posedge CLK) begin
    if (reset) begin
      console_wr_act <= 1'b0;
      mcu_wr_act     <= 1'b0;
    end else begin
      if (strobe.console_in)
        console_wr_act <= 1'b1;
      else if (strobe.mem_to_console)
        console_wr_act <= 1'b0;
      if (strobe.mcu_in)
        mcu_wr_act <= 1'b1;
      else if (strobe.mem_to_mcu)
        mcu_wr_act <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Write steering
  //////////////////////////////////////////////////

  // Direct mode writes the live MCU byte, latched mode follows mode
  assign src_byte = !mcu_ovr ? mcu_wdata : (mode ? mcu_in_q : console_in_q);
  assign src_act  = !mcu_ovr ? mcu_wr_act : (mode ? mcu_wr_act : console_wr_act);

  // Without a source the lane keeps what memory already holds
  assign wr_byte   = src_act ? src_byte : mem_byte;
  assign mem_wdata = strobe.lane ? {mem_rdata[15:8], wr_byte} : {wr_byte, mem_rdata[7:0]};
  assign mem_oe    = src_act;

  // Read side
  assign console_rdata = (console_read && mcu_ovr) ? console_out_q : '0;
  assign mcu_rdata     = !mcu_ovr ? mem_byte : mcu_out_q;

endmodule

`default_nettype wire

//--- design/cart_addr_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module cart_addr_mux (
  input  wire                       CLK,
  input  wire                       reset,
  input  wire cart_mem_pkg::owner_e owner,
  input  wire [`CART_ADDR_W-1:0]    console_addr,
  input  wire [`CART_ADDR_W-1:0]    mcu_addr,
  output logic [`CART_ADDR_W-2:0]   mem_addr,
  output logic                      lane
);

  logic [`CART_ADDR_W-1:0] addr_q;

  // Hold the last address while nobody owns the bus
  always_ff @(posedge CLK) begin
    if (reset) begin
      addr_q <= '0;
    end else begin
      case (owner)
        cart_mem_pkg::OWNER_CONSOLE: addr_q <= console_addr;
        cart_mem_pkg::OWNER_MCU:     addr_q <= mcu_addr;
        default:                     addr_q <= addr_q;
      endcase
    end
  end

  // Word address and byte lane
  assign mem_addr = addr_q[`CART_ADDR_W-1:1];
  assign lane     = addr_q[0];

endmodule

`default_nettype wire

//--- design/cart_access_seq.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module cart_access_seq (
  input  wire cart_bus_pkg::console_req_t console,
  input  wire                             CLK,
  input  wire                             reset,
  input  wire cart_bus_pkg::mcu_req_t     mcu,
  output cart_mem_pkg::owner_e            owner,
  output cart_mem_pkg::latch_strobe_t     strobe,
  output logic                            mem_we,
  output logic                            mcu_done
);

  localparam int CNT_W = $clog2(`CART_MEM_WAIT + 1);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`CART_MEM_WAIT);

  cart_mem_pkg::owner_e owner_q;
  logic [CNT_W-1:0]     cnt;
  logic                 acc_we;
  logic                 wr_q;
  logic                 console_served;
  logic                 mcu_pend;
  logic                 mcu_pend_we;
  logic                 console_want;
  logic                 last_cycle;
  logic                 grant_console;
  logic                 grant_mcu;

  //////////////////////////////////////////////////
  // Arbitration
  //////////////////////////////////////////////////

  // A held console level is served once per rise
  assign console_want  = (console.read | console.write) & ~console_served;
  assign last_cycle    = (owner_q != cart_mem_pkg::OWNER_IDLE) && (cnt == LAST);
  assign grant_console = (owner_q == cart_mem_pkg::OWNER_IDLE) && console_want;
  // Console wins a tie
  assign grant_mcu     = (owner_q == cart_mem_pkg::OWNER_IDLE) && !console_want && mcu_pend;

  always_ff @(posedge CLK) begin
    if (reset) begin
      owner_q        <= cart_mem_pkg::OWNER_IDLE;
      cnt            <= '0;
      acc_we         <= 1'b0;
      wr_q           <= 1'b0;
      console_served <= 1'b0;
      mcu_pend       <= 1'b0;
      mcu_pend_we    <= 1'b0;
    end else begin
      wr_q <= console.write;

      // One MCU request held until granted
      if (mcu.req) begin
        mcu_pend    <= 1'b1;
        mcu_pend_we <= mcu.we;
      end else if (grant_mcu) begin
        mcu_pend <= 1'b0;
      end

      if (!(console.read || console.write))
        console_served <= 1'b0;
      else if (last_cycle && owner_q == cart_mem_pkg::OWNER_CONSOLE)
        console_served <= 1'b1;

      case (owner_q)
        cart_mem_pkg::OWNER_IDLE: begin
          cnt <= '0;
          if (grant_console) begin
            owner_q <= cart_mem_pkg::OWNER_CONSOLE;
            acc_we  <= console.write;
          end else if (grant_mcu) begin
            owner_q <= cart_mem_pkg::OWNER_MCU;
            acc_we  <= mcu_pend_we;
          end
        end
        default: begin
          if (last_cycle)
            owner_q <= cart_mem_pkg::OWNER_IDLE;
          else
            cnt <= cnt + 1'b1;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////
  // Strobes and memory cycle
  //////////////////////////////////////////////////

  assign strobe.console_in     = console.write & ~wr_q;
  assign strobe.mcu_in         = grant_mcu & mcu_pend_we;
  assign strobe.mem_to_console = last_cycle && (owner_q == cart_mem_pkg::OWNER_CONSOLE);
  assign strobe.mem_to_mcu     = last_cycle && (owner_q == cart_mem_pkg::OWNER_MCU);
  // Lane comes from the address mux
  assign strobe.lane           = 1'b0;

  // First cycle waits for the registered address
  assign mem_we   = (owner_q != cart_mem_pkg::OWNER_IDLE) && acc_we && (cnt != '0);
  assign mcu_done = last_cycle && (owner_q == cart_mem_pkg::OWNER_MCU);
  assign owner    = owner_q;

endmodule

`default_nettype wire

//--- design/cart_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module cart_top (
  input  wire                             CLK,
  input  wire                             reset,
  input  wire cart_bus_pkg::console_req_t console,
  input  wire cart_bus_pkg::mcu_req_t     mcu,
  input  wire                             mode,
  input  wire                             mcu_ovr,
  input  wire [2*`CART_DATA_W-1:0]        mem_rdata,
  output logic [`CART_DATA_W-1:0]         console_rdata,
  output logic                            console_oe,
  output cart_bus_pkg::mcu_rsp_t          mcu_rsp,
  output cart_mem_pkg::mem_port_t         mem
);

  cart_mem_pkg::owner_e        owner;
  cart_mem_pkg::latch_strobe_t seq_strobe;
  cart_mem_pkg::latch_strobe_t dp_strobe;
  logic                        lane;

  // Sequencer strobes with the registered lane merged in
  always_comb begin
    dp_strobe      = seq_strobe;
    dp_strobe.lane = lane;
  end

  assign console_oe = console.read;

  cart_access_seq cart_access_seq_inst (
    .CLK      (CLK),
    .reset    (reset),
    .console  (console),
    .mcu      (mcu),
    .owner    (owner),
    .strobe   (seq_strobe),
    .mem_we   (mem.we),
    .mcu_done (mcu_rsp.done)
  );

  cart_addr_mux cart_addr_mux_inst (
    .CLK          (CLK),
    .reset        (reset),
    .owner        (owner),
    .console_addr (console.addr),
    .mcu_addr     (mcu.addr),
    .mem_addr     (mem.addr),
    .lane         (lane)
  );

  cart_data_path cart_data_path_inst (
    .CLK           (CLK),
    .reset         (reset),
    .strobe        (dp_strobe),
    .mode          (mode),
    .mcu_ovr       (mcu_ovr),
    .console_wdata (console.wdata),
    .mcu_wdata     (mcu.wdata),
    .console_read  (console.read),
    .mem_rdata     (mem_rdata),
    .mem_wdata     (mem.wdata),
    .mem_oe        (mem.oe),
    .console_rdata (console_rdata),
    .mcu_rdata     (mcu_rsp.rdata)
  );

endmodule

`default_nettype wire

//--- tests/cart_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module cart_checker (
  input  wire                             CLK,
  input  wire                             reset,
  input  wire cart_bus_pkg::console_req_t console,
  input  wire cart_bus_pkg::mcu_req_t     mcu,
  input  wire [`CART_DATA_W-1:0]          console_rdata,
  input  wire                             console_oe,
  input  wire cart_bus_pkg::mcu_rsp_t     mcu_rsp,
  input  wire cart_mem_pkg::mem_port_t    mem,
  input  wire                             check_console,
  input  wire [`CART_DATA_W-1:0]          exp_console,
  input  wire                             check_mcu,
  input  wire [`CART_DATA_W-1:0]          exp_mcu,
  output logic [31:0]                     errors,
  output logic [31:0]                     checks
);

  logic                    in_reset;
  logic                    mcu_armed;
  logic [`CART_DATA_W-1:0] mcu_exp_q;
  logic [`CART_ADDR_W-1:0] mcu_addr_q;

  always @(posedge CLK) begin : compare
    int n_err;
    int n_chk;
    n_err = 0;
    n_chk = 0;
    if (reset) begin
      errors    <= '0;
      checks    <= '0;
      mcu_armed <= 1'b0;
      in_reset  <= 1'b1;
    end else begin
      in_reset <= 1'b0;
      // First cycle out of reset
      if (in_reset && ({console_oe, mem.we, mem.oe, mcu_rsp.done} !== 4'b0000)) begin
        $display("Mismatch at %0t ns: after reset oe %b we %b mem oe %b done %b, expected all low",
                 $time, console_oe, mem.we, mem.oe, mcu_rsp.done);
        n_err++;
      end
      if (console_oe !== console.read) begin
        $display("Mismatch at %0t ns: console_oe %b does not follow read level %b",
                 $time, console_oe, console.read);
        n_err++;
      end
      if (check_console) begin
        n_chk++;
        if (console_rdata !== exp_console) begin
          $display("Mismatch at %0t ns: console read at %h got %h expected %h",
                   $time, console.addr, console_rdata, exp_console);
          n_err++;
        end
      end
      // Console has priority, so no MCU access may end under a held read
      if (mcu_rsp.done && console.read) begin
        $display("Error at %0t ns: MCU access finished while the console read was held",
                 $time);
        n_err++;
      end
      // MCU-out latch loads with done and is sampled a cycle later
      if (mcu_armed) begin
        n_chk++;
        if (mcu_rsp.rdata !== mcu_exp_q) begin
          $display("Mismatch at %0t ns: MCU read at %h got %h expected %h",
                   $time, mcu_addr_q, mcu_rsp.rdata, mcu_exp_q);
          n_err++;
        end
      end
      mcu_armed <= mcu_rsp.done && check_mcu;
      if (mcu_rsp.done && check_mcu) begin
        mcu_exp_q  <= exp_mcu;
        mcu_addr_q <= mcu.addr;
      end
      errors <= errors + n_err;
      checks <= checks + n_chk;
    end
  end

endmodule

`default_nettype wire

//--- tests/cart_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cart_config.svh"

module cart_tb;

  localparam int MAX_OPS      = 64;
  localparam int MEM_WORDS    = 1024;
  localparam int HOLD_CYCLES  = `CART_MEM_WAIT + 4;
  localparam int DONE_TIMEOUT = 50;

  logic                        CLK;
  logic                        reset;
  cart_bus_pkg::console_req_t  console;
  cart_bus_pkg::mcu_req_t      mcu;
  logic                        mode;
  logic                        mcu_ovr;
  logic [2*`CART_DATA_W-1:0]   mem_rdata;
  logic [`CART_DATA_W-1:0]     console_rdata;
  logic                        console_oe;
  cart_bus_pkg::mcu_rsp_t      mcu_rsp;
  cart_mem_pkg::mem_port_t     mem;
  logic                        check_console;
  logic                        check_mcu;
  logic [`CART_DATA_W-1:0]     exp_console;
  logic [`CART_DATA_W-1:0]     exp_mcu;
  logic [31:0]                 checker_errors;
  logic [31:0]                 checker_checks;
  logic [2*`CART_DATA_W-1:0]   mem_array [0:MEM_WORDS-1];
  logic [31:0]                 trace_words [0:4*MAX_OPS-1];
  int                          timeouts;
  int                          checks_req;

  cart_top cart_top_inst (
    .CLK           (CLK),
    .reset         (reset),
    .console       (console),
    .mcu           (mcu),
    .mode          (mode),
    .mcu_ovr       (mcu_ovr),
    .mem_rdata     (mem_rdata),
    .console_rdata (console_rdata),
    .console_oe    (console_oe),
    .mcu_rsp       (mcu_rsp),
    .mem           (mem)
  );

  cart_checker cart_checker_inst (
    .CLK           (CLK),
    .reset         (reset),
    .console       (console),
    .mcu           (mcu),
    .console_rdata (console_rdata),
    .console_oe    (console_oe),
    .mcu_rsp       (mcu_rsp),
    .mem           (mem),
    .check_console (check_console),
    .exp_console   (exp_console),
    .check_mcu     (check_mcu),
    .exp_mcu       (exp_mcu),
    .errors        (checker_errors),
    .checks        (checker_checks)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////

  // Fill depends on every bit of the word index
  function automatic logic [15:0] fill_word(input logic [9:0] idx);
    fill_word = {idx[7:0] ^ 8'h5a, {idx[9:8], idx[7:2]} ^ 8'hc3};
  endfunction

  assign mem_rdata = mem_array[mem.addr[9:0]];

  // DUT already merges the unselected lane into the write word
  always @(posedge CLK) begin
    if (mem.we)
      mem_array[mem.addr[9:0]] <= mem.wdata;
  end

  //////////////////////////////////////////////////
  // Bus drivers start and end on a falling edge
  //////////////////////////////////////////////////

  task automatic console_access(input logic is_write, input logic [23:0] addr,
                                input logic [7:0] wdata, input logic [7:0] expected);
    int n;
    console.addr  = addr;
    console.wdata = wdata;
    console.read  = !is_write;
    console.write = is_write;
    for (n = 1; n < HOLD_CYCLES; n++)
      @(negedge CLK);
    if (!is_write) begin
      exp_console   = expected;
      check_console = 1'b1;
    end
    @(negedge CLK);
    console.read  = 1'b0;
    console.write = 1'b0;
    check_console = 1'b0;
    // Level must be seen low before the next rise
    @(negedge CLK);
  endtask

  task automatic mcu_access(input logic is_write, input logic [23:0] addr,
                            input logic [7:0] wdata, input logic [7:0] expected,
                            output logic timed_out);
    int n;
    logic seen;
    mcu.addr  = addr;
    mcu.wdata = wdata;
    mcu.we    = is_write;
    mcu.req   = 1'b1;
    exp_mcu   = expected;
    check_mcu = !is_write;
    @(negedge CLK);
    mcu.req = 1'b0;
    seen    = 1'b0;
    n       = 0;
    while (!seen && n < DONE_TIMEOUT) begin
      @(negedge CLK);
      seen = mcu_rsp.done;
      n++;
    end
    timed_out = !seen;
    if (!seen)
      $display("Error at %0t ns: MCU request never completed", $time);
    @(negedge CLK);
    check_mcu = 1'b0;
    @(negedge CLK);
  endtask

  //////////////////////////////////////////////////
  // Trace sequencing
  //////////////////////////////////////////////////

  initial begin
    int         i;
    int         missed;
    logic [3:0] op;
    logic [23:0] addr;
    logic [7:0] data;
    logic [7:0] expected;
    logic       timed_out;
    logic       stop;
    reset         = 1'b1;
    console       = '0;
    mcu           = '0;
    mode          = 1'b0;
    mcu_ovr       = 1'b1;
    check_console = 1'b0;
    check_mcu     = 1'b0;
    exp_console   = '0;
    exp_mcu       = '0;
    timeouts      = 0;
    checks_req    = 0;
    missed        = 0;
    for (i = 0; i < MEM_WORDS; i++)
      mem_array[i] <= fill_word(10'(i));
    for (i = 0; i < 4*MAX_OPS; i++)
      trace_words[i] = '1;
    $readmemh("tests/cart_trace.txt", trace_words);

    for (i = 0; i < 5; i++)
      @(negedge CLK);
    reset = 1'b0;
    @(negedge CLK);
    @(negedge CLK);

    stop = 1'b0;
    for (i = 0; i < MAX_OPS && !stop; i++) begin
      op        = trace_words[4*i][3:0];
      addr      = trace_words[4*i+1][23:0];
      data      = trace_words[4*i+2][7:0];
      expected  = trace_words[4*i+3][7:0];
      timed_out = 1'b0;
      case (op)
        4'h0: begin
          mcu_ovr = data[1];
          mode    = data[0];
          @(negedge CLK);
        end
        4'h1: console_access(1'b1, addr, data, 8'h00);
        4'h2: begin
          checks_req++;
          console_access(1'b0, addr, 8'h00, expected);
        end
        4'h3: mcu_access(1'b1, addr, data, 8'h00, timed_out);
        4'h4: begin
          checks_req++;
          mcu_access(1'b0, addr, 8'h00, expected, timed_out);
        end
        // MCU request lands while the console owns the bus
        4'h5: begin
          checks_req += 2;
          fork
            console_access(1'b0, addr, 8'h00, expected);
            begin
              @(negedge CLK);
              mcu_access(1'b0, addr, 8'h00, expected, timed_out);
            end
          join
        end
        default: stop = 1'b1;
      endcase
      if (timed_out) begin
        timeouts++;
        stop = 1'b1;
      end
    end

    for (i = 0; i < 4; i++)
      @(negedge CLK);
    if (checker_checks != checks_req) begin
      $display("Error: checker completed %0d of %0d read checks", checker_checks, checks_req);
      missed = 1;
    end
    $display("Error counts: checker %0d, timeouts %0d, missed checks %0d",
             checker_errors, timeouts, missed);
    if (checker_errors == 0 && timeouts == 0 && missed == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- cart_bridge.f
+incdir+design
design/cart_bus_pkg.sv
design/cart_mem_pkg.sv
design/cart_data_path.sv
design/cart_addr_mux.sv
design/cart_access_seq.sv
design/cart_top.sv
tests/cart_checker.sv
tests/cart_tb.sv

//--- tests/cart_trace.txt
// Columns: op, byte address, write data, expected read byte
// op 0 sets data[1] mcu_ovr and data[0] mode, 1/2 console write/read,
// 3/4 MCU write/read, 5 MCU read during a console read, f ends the trace
0 000000 02 00
1 000021 3c 00
1 000040 96 00
2 000021 00 3c
2 000040 00 96
2 000020 00 4a
2 000041 00 cb
// Latched, MCU-in latch sources writes
0 000000 03 00
3 000031 e7 00
4 000031 00 e7
2 000031 00 e7
// Direct mode
0 000000 00 00
2 000021 00 00
4 000021 00 3c
4 000040 00 96
3 000050 71 00
4 000050 00 71
// Latched, console-in latch sources writes
0 000000 02 00
3 000031 11 00
4 000031 00 e7
2 000031 00 e7
5 000040 00 96
5 000021 00 3c
f 000000 00 00
